// ==== axis_out_pkg.sv ====
package axis_out_pkg;

   // Width of one stream beat
   localparam int TDATA_W = 8;

   // Word width on the CPU register port
   localparam int CPU_DATA_W = 32;

   // Stream lanes packed in one CPU word
   localparam int N_LANES = CPU_DATA_W / TDATA_W;

   // Bits that pick one lane inside a word
   localparam int LANE_SEL_W = $clog2(N_LANES);

   // FIFO depth counted in lanes, 32 lanes or 8 words
   localparam int LANE_DEPTH_LOG2 = 5;
   localparam int LANE_DEPTH = 2 ** LANE_DEPTH_LOG2;

   // Word address of the storage array
   localparam int WORD_ADDR_W = LANE_DEPTH_LOG2 - LANE_SEL_W;

   // Level runs 0 to LANE_DEPTH inclusive, one bit wider than the lane pointer
   localparam int LEVEL_W = LANE_DEPTH_LOG2 + 1;

   // One stream lane
   typedef logic [TDATA_W-1:0] lane_t;

   // One bit per lane of a CPU word
   typedef logic [N_LANES-1:0] lane_mask_t;

   // FIFO fill in lanes
   typedef logic [LEVEL_W-1:0] level_t;

endpackage

// ==== axis_out_csr_pkg.sv ====
package axis_out_csr_pkg;

   // Register port address width
   localparam int CSR_ADDR_W = 3;

   // Register map
   localparam logic [CSR_ADDR_W-1:0] ADDR_CTRL       = 3'd0;
   localparam logic [CSR_ADDR_W-1:0] ADDR_IN         = 3'd1;
   localparam logic [CSR_ADDR_W-1:0] ADDR_LAST_WSTRB = 3'd2;
   localparam logic [CSR_ADDR_W-1:0] ADDR_STATUS     = 3'd3;

   // CTRL fields
   localparam int CTRL_ENABLE_BIT    = 0;
   localparam int CTRL_SOFTRESET_BIT = 1;

   // STATUS fields
   localparam int STATUS_FULL_BIT  = 0;
   localparam int STATUS_LEVEL_LSB = 8;

   // Control view of a CPU word
   // CTRL uses bits 0 and 1, LAST_WSTRB uses all four low bits
   typedef struct packed {
      logic [axis_out_pkg::CPU_DATA_W-axis_out_pkg::N_LANES-1:0] unused;
      axis_out_pkg::lane_mask_t                                  low_bits;
   } csr_fields_t;

   // One CPU write word, read as data lanes or as control fields
   // Lane 0 sits in the least significant byte
   typedef union packed {
      axis_out_pkg::lane_t [axis_out_pkg::N_LANES-1:0] lanes;
      csr_fields_t                                     fields;
   } csr_word_u;

endpackage

// ==== axis_out_fifo_if.sv ====
`timescale 1ns/10ps

interface axis_out_fifo_if;
   import axis_out_pkg::*;

   // Pop request from the transmitter
   logic   r_en;
   // Popped lane, valid the cycle after the pop
   lane_t  r_data;
   // No lanes stored
   logic   empty;
   // Stored lanes, used to find the final word of a packet
   level_t level;

   // FIFO side
   modport fifo_mp (
      input  r_en,
      output r_data,
      output empty,
      output level
   );

   // Transmitter side
   modport tx_mp (
      output r_en,
      input  r_data,
      input  empty,
      input  level
   );

endinterface

// ==== axis_out_csr.sv ====
`timescale 1ns/10ps

module axis_out_csr (
   input  logic                                    clk_i,
   input  logic                                    rst_i,
   input  logic                                    csr_valid_i,
   input  logic                                    csr_wen_i,
   input  logic [axis_out_csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
   input  axis_out_csr_pkg::csr_word_u             csr_wdata_i,
   output logic [axis_out_pkg::CPU_DATA_W-1:0]     csr_rdata_o,
   output logic                                    fifo_w_en_o,
   output logic [axis_out_pkg::CPU_DATA_W-1:0]     fifo_w_data_o,
   output logic                                    soft_rst_o,
   output logic                                    enable_o,
   output axis_out_pkg::lane_mask_t                last_mask_o,
   output logic                                    storing_last_o,
   input  logic                                    fifo_full_i,
   input  axis_out_pkg::level_t                    fifo_level_i,
   input  logic                                    last_done_i
);
   import axis_out_pkg::*;
   import axis_out_csr_pkg::*;

   logic                  wr_strobe;
   logic                  rd_strobe;
   logic                  wr_ctrl;
   logic                  wr_in;
   logic                  wr_wstrb;
   logic                  pkt_clear;
   logic                  status_full;
   logic                  ctrl_enable_q;
   logic                  ctrl_softrst_q;
   lane_mask_t            last_mask_q;
   logic                  storing_last_q;
   logic [CPU_DATA_W-1:0] rd_word;

   // Address decode of the strobe
   assign wr_strobe = csr_valid_i & csr_wen_i;
   assign rd_strobe = csr_valid_i & ~csr_wen_i;
   assign wr_ctrl   = wr_strobe & (csr_addr_i == ADDR_CTRL);
   assign wr_in     = wr_strobe & (csr_addr_i == ADDR_IN);
   assign wr_wstrb  = wr_strobe & (csr_addr_i == ADDR_LAST_WSTRB);

   // IN write goes straight to the FIFO on the same edge
   assign fifo_w_en_o   = wr_in;
   assign fifo_w_data_o = csr_wdata_i.lanes;

   // Packet state ends on soft reset or once the final word has drained
   assign pkt_clear = ctrl_softrst_q | last_done_i;

   // CTRL register, both bits are plain levels
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ctrl_enable_q  <= 1'b0;
         ctrl_softrst_q <= 1'b0;
      end else if (wr_ctrl) begin
         ctrl_enable_q  <= csr_wdata_i.fields.low_bits[CTRL_ENABLE_BIT];
         ctrl_softrst_q <= csr_wdata_i.fields.low_bits[CTRL_SOFTRESET_BIT];
      end
   end

   // Lane mask of the final word
   always_ff @(posedge clk_i) begin
      if (rst_i || pkt_clear) begin
         last_mask_q <= '0;
      end else if (wr_wstrb) begin
         last_mask_q <= csr_wdata_i.fields.low_bits;
      end
   end

   // Final word is in the FIFO
   // Only set when the FIFO actually accepts the word
   always_ff @(posedge clk_i) begin
      if (rst_i || pkt_clear) begin
         storing_last_q <= 1'b0;
      end else if (wr_in && (|last_mask_q) && !fifo_full_i) begin
         storing_last_q <= 1'b1;
      end
   end

   // Software sees full while a packet end is pending too
   assign status_full = fifo_full_i | (|last_mask_q);

   // Read mux, IN reads back as zero
   always_comb begin
      rd_word = '0;
      case (csr_addr_i)
         ADDR_CTRL: begin
            rd_word[CTRL_ENABLE_BIT]    = ctrl_enable_q;
            rd_word[CTRL_SOFTRESET_BIT] = ctrl_softrst_q;
         end
         ADDR_LAST_WSTRB: rd_word[N_LANES-1:0] = last_mask_q;
         ADDR_STATUS: begin
            rd_word[STATUS_FULL_BIT]              = status_full;
            rd_word[STATUS_LEVEL_LSB +: LEVEL_W] = fifo_level_i;
         end
         default: rd_word = '0;
      endcase
   end

   // Registered read data, one cycle after the strobe
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         csr_rdata_o <= '0;
      end else if (rd_strobe) begin
         csr_rdata_o <= rd_word;
      end
   end

   assign soft_rst_o     = ctrl_softrst_q;
   assign enable_o       = ctrl_enable_q;
   assign last_mask_o    = last_mask_q;
   assign storing_last_o = storing_last_q;

endmodule

// ==== axis_out_fifo.sv ====
`timescale 1ns/10ps

module axis_out_fifo (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  logic                                soft_rst_i,
   input  logic                                w_en_i,
   input  logic [axis_out_pkg::CPU_DATA_W-1:0] w_data_i,
   output logic                                full_o,
   axis_out_fifo_if.fifo_mp                    rd
);
   import axis_out_pkg::*;

   // Word storage, each entry split into lanes
   lane_t [N_LANES-1:0]        mem [0:(2**WORD_ADDR_W)-1];

   logic [WORD_ADDR_W-1:0]     w_ptr;
   // Upper bits address the word, low bits pick the lane
   logic [LANE_DEPTH_LOG2-1:0] r_ptr;
   logic [WORD_ADDR_W-1:0]     r_word;
   logic [LANE_SEL_W-1:0]      r_lane;
   level_t                     level;
   lane_t                      r_data_q;
   logic                       push;
   logic                       pop;

   // Writes while full are dropped, soft reset blocks both sides
   assign push = w_en_i & ~full_o & ~soft_rst_i;
   assign pop  = rd.r_en & ~rd.empty & ~soft_rst_i;

   assign r_word = r_ptr[LANE_DEPTH_LOG2-1:LANE_SEL_W];
   assign r_lane = r_ptr[LANE_SEL_W-1:0];

   // Storage write, no reset on the array
   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[w_ptr] <= w_data_i;
      end
   end

   // Pointers
   always_ff @(posedge clk_i) begin
      if (rst_i || soft_rst_i) begin
         w_ptr <= '0;
         r_ptr <= '0;
      end else begin
         if (push) begin
            w_ptr <= w_ptr + 1'b1;
         end
         if (pop) begin
            r_ptr <= r_ptr + 1'b1;
         end
      end
   end

   // Level in lanes
   // A word adds four lanes, a pop takes one
   always_ff @(posedge clk_i) begin
      if (rst_i || soft_rst_i) begin
         level <= '0;
      end else begin
         level <= level + (push ? level_t'(N_LANES) : level_t'(0)) - level_t'(pop);
      end
   end

   // Output lane register, lane 0 of each word leaves first
   always_ff @(posedge clk_i) begin
      if (pop) begin
         r_data_q <= mem[r_word][r_lane];
      end
   end

   // No room for another full word
   assign full_o = level > level_t'(LANE_DEPTH - N_LANES);

   assign rd.empty  = (level == '0);
   assign rd.level  = level;
   assign rd.r_data = r_data_q;

endmodule

// ==== axis_out_tx.sv ====
`timescale 1ns/10ps

module axis_out_tx (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     soft_rst_i,
   input  logic                     enable_i,
   input  axis_out_pkg::lane_mask_t last_mask_i,
   input  logic                     storing_last_i,
   input  logic                     tready_i,
   output axis_out_pkg::lane_t      tdata_o,
   output logic                     tvalid_o,
   output logic                     tlast_o,
   output logic                     last_done_o,
   axis_out_fifo_if.tx_mp           rd
);
   import axis_out_pkg::*;

   logic                  tvalid_q;
   logic                  tlast_q;
   logic                  pop;
   logic                  in_last_word;
   logic [LANE_SEL_W-1:0] lane_sel;
   logic [LANE_SEL_W-1:0] next_sel;
   logic                  lane_keep;
   logic                  lane_is_last;

   // Pop when the output slot is free or being taken this cycle
   // A held beat blocks the pop under back-pressure
   assign pop      = enable_i & ~rd.empty & (tready_i | ~tvalid_q);
   assign rd.r_en  = pop;

   // Final word is the last four lanes once storing_last is set
   assign in_last_word = storing_last_i & (rd.level <= level_t'(N_LANES));

   // Lane index inside the final word, level 4 is lane 0
   assign lane_sel = LANE_SEL_W'(level_t'(N_LANES) - rd.level);
   assign next_sel = lane_sel + 1'b1;

   // Lanes outside the mask are popped and discarded
   assign lane_keep = ~in_last_word | last_mask_i[lane_sel];

   // Last kept lane, mask assumed contiguous from lane 0
   assign lane_is_last = in_last_word & last_mask_i[lane_sel] &
                         ((rd.level == level_t'(1)) | ~last_mask_i[next_sel]);

   // Beat registers
   // Hold while valid and not ready, clear once taken
   always_ff @(posedge clk_i) begin
      if (rst_i || soft_rst_i) begin
         tvalid_q <= 1'b0;
         tlast_q  <= 1'b0;
      end else if (pop) begin
         tvalid_q <= lane_keep;
         tlast_q  <= lane_is_last;
      end else if (tready_i) begin
         tvalid_q <= 1'b0;
         tlast_q  <= 1'b0;
      end
   end

   // FIFO lane register holds its value between pops
   assign tdata_o  = rd.r_data;
   assign tvalid_o = tvalid_q;

   // tlast only counts on a valid beat
   assign tlast_o = tlast_q & tvalid_q;

   // Final word fully popped
   assign last_done_o = storing_last_i & rd.empty;

endmodule

// ==== axis_out_top.sv ====
`timescale 1ns/10ps

module axis_out_top (
   input  logic                                    clk_i,
   input  logic                                    rst_i,
   input  logic                                    csr_valid_i,
   input  logic                                    csr_wen_i,
   input  logic [axis_out_csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
   input  logic [axis_out_pkg::CPU_DATA_W-1:0]     csr_wdata_i,
   output logic [axis_out_pkg::CPU_DATA_W-1:0]     csr_rdata_o,
   output logic [axis_out_pkg::TDATA_W-1:0]        tdata_o,
   output logic                                    tvalid_o,
   output logic                                    tlast_o,
   input  logic                                    tready_i
);
   import axis_out_pkg::*;

   logic                  fifo_w_en;
   logic [CPU_DATA_W-1:0] fifo_w_data;
   logic                  fifo_full;
   logic                  soft_rst;
   logic                  enable;
   lane_mask_t            last_mask;
   logic                  storing_last;
   logic                  last_done;

   // FIFO read side to the transmitter
   axis_out_fifo_if fifo_if ();

   // Register file and packet state
   axis_out_csr u_csr (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .csr_valid_i   (csr_valid_i),
      .csr_wen_i     (csr_wen_i),
      .csr_addr_i    (csr_addr_i),
      .csr_wdata_i   (csr_wdata_i),
      .csr_rdata_o   (csr_rdata_o),
      .fifo_w_en_o   (fifo_w_en),
      .fifo_w_data_o (fifo_w_data),
      .soft_rst_o    (soft_rst),
      .enable_o      (enable),
      .last_mask_o   (last_mask),
      .storing_last_o(storing_last),
      .fifo_full_i   (fifo_full),
      .fifo_level_i  (fifo_if.level),
      .last_done_i   (last_done)
   );

   // Word in, lane out
   axis_out_fifo u_fifo (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .soft_rst_i(soft_rst),
      .w_en_i    (fifo_w_en),
      .w_data_i  (fifo_w_data),
      .full_o    (fifo_full),
      .rd        (fifo_if.fifo_mp)
   );

   // Stream master
   axis_out_tx u_tx (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .soft_rst_i    (soft_rst),
      .enable_i      (enable),
      .last_mask_i   (last_mask),
      .storing_last_i(storing_last),
      .tready_i      (tready_i),
      .tdata_o       (tdata_o),
      .tvalid_o      (tvalid_o),
      .tlast_o       (tlast_o),
      .last_done_o   (last_done),
      .rd            (fifo_if.tx_mp)
   );

endmodule

// ==== axis_out_asserts.sv ====
`timescale 1ns/10ps

module axis_out_asserts (
   input logic                clk_i,
   input logic                rst_i,
   input logic                soft_rst_i,
   input logic                tready_i,
   input logic                tvalid_o,
   input logic                tlast_o,
   input logic                tlast_reg_i,
   input axis_out_pkg::lane_t tdata_o
);

   // Count of failed checks, read by the testbench at the end of the run
   int unsigned fail_count = 0;

   // A stalled beat keeps its data, valid and last unless soft reset clears it
   hold_under_stall_a : assert property (
      @(posedge clk_i) disable iff (rst_i)
      (tvalid_o && !tready_i && !soft_rst_i) |=>
         (tvalid_o && $stable(tdata_o) && $stable(tlast_o))
   ) else begin
      fail_count++;
      $error("Stream beat changed while tready was low");
   end

   // Registered last flag only set on a valid beat
   last_needs_valid_a : assert property (
      @(posedge clk_i) disable iff (rst_i)
      tlast_reg_i |-> tvalid_o
   ) else begin
      fail_count++;
      $error("tlast register high without tvalid");
   end

   // Soft reset clears the beat one edge after it is seen
   idle_in_soft_reset_a : assert property (
      @(posedge clk_i) disable iff (rst_i)
      soft_rst_i |=> !tvalid_o
   ) else begin
      fail_count++;
      $error("tvalid high during soft reset");
   end

endmodule

// ==== tb_axis_out.sv ====
`timescale 1ns/10ps

module tb_axis_out;
   import axis_out_pkg::*;
   import axis_out_csr_pkg::*;

   localparam int CLK_PERIOD     = 20;
   localparam int TIMEOUT_CYCLES = 1000;
   localparam int MAX_POLLS      = 200;

   logic                  clk_i;
   logic                  rst_i;
   logic                  csr_valid_i;
   logic                  csr_wen_i;
   logic [CSR_ADDR_W-1:0] csr_addr_i;
   logic [CPU_DATA_W-1:0] csr_wdata_i;
   logic [CPU_DATA_W-1:0] csr_rdata_o;
   lane_t                 tdata_o;
   logic                  tvalid_o;
   logic                  tlast_o;
   logic                  tready_i;

   // tready source, a fixed level or a random bit per cycle
   integer                seed;
   logic [31:0]           rnd;
   logic                  ready_random;
   logic                  ready_level;

   // Received beats and the lanes expected for them
   lane_t                 got_lanes[$];
   logic                  got_last[$];
   lane_t                 exp_lanes[$];
   logic [CPU_DATA_W-1:0] rand_words [0:5];

   axis_out_top UUT (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .csr_valid_i(csr_valid_i),
      .csr_wen_i  (csr_wen_i),
      .csr_addr_i (csr_addr_i),
      .csr_wdata_i(csr_wdata_i),
      .csr_rdata_o(csr_rdata_o),
      .tdata_o    (tdata_o),
      .tvalid_o   (tvalid_o),
      .tlast_o    (tlast_o),
      .tready_i   (tready_i)
   );

   // Stream port checks on the transmitter
   bind axis_out_tx axis_out_asserts u_tx_asserts (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .soft_rst_i (soft_rst_i),
      .tready_i   (tready_i),
      .tvalid_o   (tvalid_o),
      .tlast_o    (tlast_o),
      .tlast_reg_i(tlast_q),
      .tdata_o    (tdata_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // New random draw every falling edge
   always @(negedge clk_i) begin
      rnd <= $random(seed);
   end

   assign tready_i = ready_random ? rnd[0] : ready_level;

   task stop_run(input string why);
      $display("Some tests failed");
      $fatal(1, "%s", why);
   endtask

   task check_lane(input lane_t got, input lane_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
         stop_run("Lane data mismatch");
      end
   endtask

   task check_word(input logic [CPU_DATA_W-1:0] got, input logic [CPU_DATA_W-1:0] exp,
                   input string what);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
         stop_run("Word mismatch");
      end
   endtask

   task check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s got %b expected %b", $time, what, got, exp);
         stop_run("Flag mismatch");
      end
   endtask

   // CPU access, called on a falling edge and returns on the next one
   task csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [CPU_DATA_W-1:0] data);
      csr_valid_i = 1'b1;
      csr_wen_i   = 1'b1;
      csr_addr_i  = addr;
      csr_wdata_i = data;
      @(negedge clk_i);
      csr_valid_i = 1'b0;
      csr_wen_i   = 1'b0;
   endtask

   // Read data is registered at the edge inside the strobe cycle
   task csr_read(input logic [CSR_ADDR_W-1:0] addr, output logic [CPU_DATA_W-1:0] data);
      csr_valid_i = 1'b1;
      csr_wen_i   = 1'b0;
      csr_addr_i  = addr;
      @(negedge clk_i);
      csr_valid_i = 1'b0;
      data = csr_rdata_o;
   endtask

   task wait_not_full();
      logic [CPU_DATA_W-1:0] status;
      int                    polls;
      polls = 0;
      csr_read(ADDR_STATUS, status);
      while (status[STATUS_FULL_BIT]) begin
         polls++;
         if (polls > MAX_POLLS) begin
            stop_run("Timed out polling the STATUS full flag");
         end
         csr_read(ADDR_STATUS, status);
      end
   endtask

   // Beat seen a little after the falling edge is taken on the next rising edge
   task recv_lanes(input int count);
      int cycles;
      got_lanes.delete();
      got_last.delete();
      cycles = 0;
      while (got_lanes.size() < count) begin
         #1;
         if (tvalid_o && tready_i) begin
            got_lanes.push_back(tdata_o);
            got_last.push_back(tlast_o);
         end
         @(negedge clk_i);
         cycles++;
         if (cycles > TIMEOUT_CYCLES) begin
            stop_run("Timed out waiting for stream lanes");
         end
      end
   endtask

   // No beat may appear for a number of cycles
   task check_idle(input int cycles);
      repeat (cycles) begin
         #1;
         check_bit(tvalid_o, 1'b0, "tvalid_o while idle");
         @(negedge clk_i);
      end
   endtask

   // Lane 0 is the least significant byte
   task add_word_lanes(input logic [CPU_DATA_W-1:0] word, input int n);
      for (int k = 0; k < n; k++) begin
         exp_lanes.push_back(word[k*TDATA_W +: TDATA_W]);
      end
   endtask

   task check_received(input logic with_last);
      check_word(32'(got_lanes.size()), 32'(exp_lanes.size()), "lane count");
      for (int k = 0; k < exp_lanes.size(); k++) begin
         check_lane(got_lanes[k], exp_lanes[k], $sformatf("lane %0d", k));
         check_bit(got_last[k], with_last && (k == exp_lanes.size() - 1),
                   $sformatf("tlast of lane %0d", k));
      end
   endtask

   function automatic logic [CPU_DATA_W-1:0] status_word(input logic full, input level_t level);
      logic [CPU_DATA_W-1:0] w;
      w = '0;
      w[STATUS_FULL_BIT] = full;
      w[STATUS_LEVEL_LSB +: LEVEL_W] = level;
      return w;
   endfunction

   task test_after_reset();
      logic [CPU_DATA_W-1:0] status;
      check_bit(tvalid_o, 1'b0, "tvalid_o after reset");
      check_bit(tlast_o, 1'b0, "tlast_o after reset");
      csr_read(ADDR_STATUS, status);
      check_word(status, status_word(1'b0, '0), "STATUS after reset");
   endtask

   task test_lane_order();
      ready_level = 1'b1;
      csr_write(ADDR_CTRL, 32'h1);
      exp_lanes.delete();
      add_word_lanes(32'h44332211, N_LANES);
      add_word_lanes(32'h88776655, N_LANES);
      fork
         begin
            csr_write(ADDR_IN, 32'h44332211);
            csr_write(ADDR_IN, 32'h88776655);
         end
         recv_lanes(2 * N_LANES);
      join
      check_received(1'b0);
      check_idle(8);
   endtask

   task test_partial_last();
      lane_mask_t            mask;
      logic [CPU_DATA_W-1:0] status;
      for (int m = 1; m <= N_LANES; m++) begin
         mask = lane_mask_t'((1 << m) - 1);
         exp_lanes.delete();
         // Load the packet while stopped so the whole of it is queued
         csr_write(ADDR_CTRL, 32'h0);
         csr_write(ADDR_IN, 32'ha0b0c0d0 + m);
         add_word_lanes(32'ha0b0c0d0 + m, N_LANES);
         csr_write(ADDR_LAST_WSTRB, 32'(mask));
         csr_write(ADDR_IN, 32'h15263748 ^ m);
         add_word_lanes(32'h15263748 ^ m, m);
         csr_write(ADDR_CTRL, 32'h1);
         recv_lanes(N_LANES + m);
         check_received(1'b1);
         // Lanes outside the mask drain without a beat
         check_idle(8);
         csr_read(ADDR_STATUS, status);
         check_word(status, status_word(1'b0, '0), $sformatf("STATUS after mask %b", mask));
      end
   endtask

   task test_random_ready();
      logic [CPU_DATA_W-1:0] status;
      exp_lanes.delete();
      for (int i = 0; i < 6; i++) begin
         add_word_lanes(rand_words[i], N_LANES);
      end
      ready_random = 1'b1;
      fork
         begin
            for (int i = 0; i < 5; i++) begin
               wait_not_full();
               csr_write(ADDR_IN, rand_words[i]);
            end
            // Full stays set once the mask is written
            wait_not_full();
            csr_write(ADDR_LAST_WSTRB, 32'hf);
            csr_write(ADDR_IN, rand_words[5]);
         end
         recv_lanes(6 * N_LANES);
      join
      check_received(1'b1);
      ready_random = 1'b0;
      ready_level  = 1'b1;
      check_idle(8);
      csr_read(ADDR_STATUS, status);
      check_word(status, status_word(1'b0, '0), "STATUS after random packet");
   endtask

   task test_enable_softrst();
      logic [CPU_DATA_W-1:0] status;
      ready_level = 1'b1;
      csr_write(ADDR_CTRL, 32'h0);
      csr_write(ADDR_IN, 32'hcafe0001);
      csr_write(ADDR_IN, 32'hcafe0002);
      check_idle(8);
      csr_read(ADDR_STATUS, status);
      check_word(status, status_word(1'b0, level_t'(2 * N_LANES)), "STATUS while disabled");
      // Enable with tready low so one beat stalls on the port
      ready_level = 1'b0;
      csr_write(ADDR_CTRL, 32'h1);
      // Soft reset pulse lands on the stalled beat
      csr_write(ADDR_CTRL, 32'h2);
      check_bit(tvalid_o, 1'b1, "tvalid_o stalled before soft reset");
      csr_write(ADDR_CTRL, 32'h0);
      check_bit(tvalid_o, 1'b0, "tvalid_o after soft reset");
      csr_read(ADDR_STATUS, status);
      check_word(status, status_word(1'b0, '0), "STATUS after soft reset");
      ready_level = 1'b1;
      csr_write(ADDR_CTRL, 32'h1);
      check_idle(16);
   endtask

   task test_full_flag();
      logic [CPU_DATA_W-1:0] status;
      ready_level = 1'b0;
      csr_write(ADDR_CTRL, 32'h1);
      exp_lanes.delete();
      for (int i = 0; i < 8; i++) begin
         csr_write(ADDR_IN, 32'h10203040 + i * 32'h01010101);
         add_word_lanes(32'h10203040 + i * 32'h01010101, N_LANES);
      end
      csr_read(ADDR_STATUS, status);
      check_bit(status[STATUS_FULL_BIT], 1'b1, "STATUS full after eight words");
      // Dropped, no room left
      csr_write(ADDR_IN, 32'hdeadbeef);
      ready_level = 1'b1;
      recv_lanes(8 * N_LANES);
      check_received(1'b0);
      check_idle(16);
   endtask

   initial begin
      seed         = 32'h5f4e;
      rst_i        = 1'b1;
      csr_valid_i  = 1'b0;
      csr_wen_i    = 1'b0;
      csr_addr_i   = '0;
      csr_wdata_i  = '0;
      ready_random = 1'b0;
      ready_level  = 1'b0;
      // Packet data drawn before the per-cycle tready draws start
      for (int i = 0; i < 6; i++) begin
         rand_words[i] = $random(seed);
      end
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;

      test_after_reset();
      test_lane_order();
      test_partial_last();
      test_random_ready();
      test_enable_softrst();
      test_full_flag();

      if (UUT.u_tx.u_tx_asserts.fail_count != 0) begin
         $display("Some tests failed");
         $fatal(1, "Stream port assertions failed");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

// ==== flist.f ====
axis_out_pkg.sv
axis_out_csr_pkg.sv
axis_out_fifo_if.sv
axis_out_csr.sv
axis_out_fifo.sv
axis_out_tx.sv
axis_out_top.sv
axis_out_asserts.sv
tb_axis_out.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module tb_axis_out -f flist.f -o tb_axis_out \
   && ./obj_dir/tb_axis_out \
   || exit 1
